//--- common/sincos_defs.svh
`ifndef SINCOS_DEFS_SVH
`define SINCOS_DEFS_SVH

// Number of output channels, each with its own phase shift
`define SINCOS_N_PHASES 6

// Width of angles and samples; an angle of 2**WIDTH is one full turn
`define SINCOS_DATA_WIDTH 16

// Quarter-wave table address bits, 64 entries per quadrant
`define SINCOS_LUT_ADDR_BITS 6

// Location of the shift register block in the host address map
`define SINCOS_BASE_ADDR 'h43c00000

`endif

//--- common/sincos_pkg.sv
`default_nettype none

`include "sincos_defs.svh"

package sincos_pkg;

    // Unsigned angle, the full range of the vector is one turn
    typedef logic [`SINCOS_DATA_WIDTH-1:0] angle_t;

    // Two's complement sample, full scale is +/-32767
    typedef logic signed [`SINCOS_DATA_WIDTH-1:0] sample_t;

    // Channel index, travels with the samples as dest
    typedef logic [$clog2(`SINCOS_N_PHASES)-1:0] chan_t;

    typedef logic [31:0] axil_addr_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [1:0] axil_resp_t;

    typedef enum logic {seq_idle, seq_issue} seq_state_e;

    typedef enum logic [1:0] {wr_idle, wr_wait_data, wr_wait_addr, wr_resp} axil_wr_state_e;

endpackage

`default_nettype wire

//--- dv/multiphase_sin_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "sincos_defs.svh"

module multiphase_sin_props (
    input wire                    clock,
    input wire                    reset,
    input wire                    phase_valid,
    input wire                    phase_ready,
    input wire                    sin_valid,
    input wire                    cos_valid,
    input wire sincos_pkg::chan_t sin_dest,
    input wire                    bvalid,
    input wire                    bready,
    input wire                    rvalid,
    input wire                    rready
);

    localparam int N = `SINCOS_N_PHASES;

    valid_pairs: assert property (@(posedge clock) disable iff (!reset)
        sin_valid == cos_valid)
        else $error("sin_valid and cos_valid disagree");

    // The input stays closed while the channels of an accepted angle are issued
    input_closed: assert property (@(posedge clock) disable iff (!reset)
        phase_valid && phase_ready |=> (!phase_ready) [*N])
        else $error("phase_ready rose too early after an acceptance");

    // Every run of samples starts at channel 0 and counts up without gaps
    run_start: assert property (@(posedge clock) disable iff (!reset)
        sin_valid && !$past(sin_valid) |-> sin_dest == 0)
        else $error("sample run does not start at channel 0");

    dest_step: assert property (@(posedge clock) disable iff (!reset)
        sin_valid && sin_dest != N - 1 |=> sin_valid && sin_dest == $past(sin_dest) + 1)
        else $error("sample run broken before the last channel");

    run_wrap: assert property (@(posedge clock) disable iff (!reset)
        sin_valid && sin_dest == N - 1 |=> !sin_valid || sin_dest == 0)
        else $error("sample after the last channel is not channel 0");

    bresp_held: assert property (@(posedge clock) disable iff (!reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rresp_held: assert property (@(posedge clock) disable iff (!reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

endmodule

bind multiphase_sinusoid_generator multiphase_sin_props generator_props_i (
    .clock      (clock),
    .reset      (reset),
    .phase_valid(phase_valid),
    .phase_ready(phase_ready),
    .sin_valid  (sin_valid),
    .cos_valid  (cos_valid),
    .sin_dest   (sin_dest),
    .bvalid     (1'b0),
    .bready     (1'b0),
    .rvalid     (1'b0),
    .rready     (1'b0)
);

bind phase_shift_regs multiphase_sin_props regs_props_i (
    .clock      (clock),
    .reset      (reset),
    .phase_valid(1'b0),
    .phase_ready(1'b0),
    .sin_valid  (1'b0),
    .cos_valid  (1'b0),
    .sin_dest   ('0),
    .bvalid     (s_axil_bvalid),
    .bready     (s_axil_bready),
    .rvalid     (s_axil_rvalid),
    .rready     (s_axil_rready)
);

`default_nettype wire

//--- dv/multiphase_sin_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sincos_defs.svh"

module multiphase_sin_tb;

    localparam int N = `SINCOS_N_PHASES;
    localparam int DW = `SINCOS_DATA_WIDTH;
    localparam int AW = `SINCOS_LUT_ADDR_BITS;
    localparam int MAX_CYCLES = 4000;
    localparam logic [31:0] BASE = `SINCOS_BASE_ADDR;
    localparam real PI = 3.14159265358979;

    logic clock;
    logic reset;
    logic s_axil_awvalid, s_axil_awready, s_axil_wvalid, s_axil_wready;
    logic s_axil_bvalid, s_axil_bready, s_axil_arvalid, s_axil_arready;
    logic s_axil_rvalid, s_axil_rready;
    sincos_pkg::axil_addr_t s_axil_awaddr, s_axil_araddr;
    sincos_pkg::axil_data_t s_axil_wdata, s_axil_rdata;
    logic [3:0] s_axil_wstrb;
    sincos_pkg::axil_resp_t s_axil_bresp, s_axil_rresp;
    logic phase_valid, phase_ready, sin_valid, cos_valid;
    sincos_pkg::angle_t phase_data;
    sincos_pkg::sample_t sin_data, cos_data;
    sincos_pkg::chan_t sin_dest, cos_dest;

    int cycles = 0;
    int errors = 0;
    int tests = 0;
    int samples = 0;
    int last_accept = -1;
    bit hold_mode = 0;
    bit stall_mode = 0;
    int sine_table [1 << AW];
    sincos_pkg::angle_t shift_model [N];
    int exp_chan [$];
    int exp_sin [$];
    int exp_cos [$];
    int exp_edge [$];

    multiphase_sin_top multiphase_sin_top_i (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // Quarter-wave rule: odd quadrants mirror the index, the second half negates
    function automatic int expected_sample(input sincos_pkg::angle_t theta);
        int quad;
        int idx;
        quad = theta >> (DW - 2);
        idx = (theta >> (DW - 2 - AW)) % (1 << AW);
        if (quad % 2 == 1) begin
            idx = (1 << AW) - 1 - idx;
        end
        return (quad >= 2) ? -sine_table[idx] : sine_table[idx];
    endfunction

    // Sampled on the falling edge, where everything driven or registered is settled
    always @(negedge clock) begin
        sincos_pkg::angle_t theta;
        if (reset && phase_valid && phase_ready) begin
            if (hold_mode && last_accept >= 0 && cycles + 1 - last_accept != N + 1) begin
                report_error($sformatf("angle accepted %0d cycles after the previous one",
                    cycles + 1 - last_accept));
            end
            last_accept = cycles + 1;
            for (int i = 0; i < N; i++) begin
                theta = phase_data + shift_model[i];
                exp_chan.push_back(i);
                exp_sin.push_back(expected_sample(theta));
                exp_cos.push_back(expected_sample(theta + 16'h4000));
                exp_edge.push_back(cycles + 5 + i);
            end
        end
        if (reset && (sin_valid || cos_valid)) begin
            samples++;
            if (sin_valid != cos_valid) begin
                report_error("sin_valid and cos_valid differ");
            end else if (exp_chan.size() == 0) begin
                report_error("output sample appeared with nothing expected");
            end else begin
                if (sin_dest != exp_chan[0] || cos_dest != exp_chan[0] ||
                    int'(sin_data) != exp_sin[0] || int'(cos_data) != exp_cos[0]) begin
                    report_error($sformatf("dest %0d/%0d sin %0d cos %0d, expected %0d: %0d %0d",
                        sin_dest, cos_dest, sin_data, cos_data, exp_chan[0], exp_sin[0],
                        exp_cos[0]));
                end
                if (cycles != exp_edge[0]) begin
                    report_error($sformatf("channel %0d at edge %0d, expected edge %0d",
                        exp_chan[0], cycles, exp_edge[0]));
                end
                void'(exp_chan.pop_front());
                void'(exp_sin.pop_front());
                void'(exp_cos.pop_front());
                void'(exp_edge.pop_front());
            end
        end
    end

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        bit aw_done;
        bit w_done;
        bit aw_fire;
        bit w_fire;
        int w_delay;
        aw_done = 0;
        w_done = 0;
        w_delay = $urandom % 3;
        s_axil_awaddr = addr;
        s_axil_wdata = data;
        s_axil_wstrb = strb;
        s_axil_awvalid = 1'b1;
        while (!aw_done || !w_done) begin
            // Write data trails the address by a random number of cycles
            if (w_delay == 0 && !w_done) begin
                s_axil_wvalid = 1'b1;
            end
            w_delay--;
            @(negedge clock);
            aw_fire = s_axil_awvalid && s_axil_awready;
            w_fire = s_axil_wvalid && s_axil_wready;
            @(posedge clock);
            #1;
            if (aw_fire) begin
                s_axil_awvalid = 1'b0;
                aw_done = 1;
            end
            if (w_fire) begin
                s_axil_wvalid = 1'b0;
                w_done = 1;
            end
        end
        idle(stall_mode ? $urandom % 4 : 0);
        s_axil_bready = 1'b1;
        do begin
            @(negedge clock);
        end while (!s_axil_bvalid);
        resp = s_axil_bresp;
        @(posedge clock);
        #1;
        s_axil_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        s_axil_araddr = addr;
        s_axil_arvalid = 1'b1;
        do begin
            @(negedge clock);
        end while (!s_axil_arready);
        @(posedge clock);
        #1;
        s_axil_arvalid = 1'b0;
        idle(stall_mode ? $urandom % 4 : 0);
        s_axil_rready = 1'b1;
        do begin
            @(negedge clock);
        end while (!s_axil_rvalid);
        data = s_axil_rdata;
        resp = s_axil_rresp;
        @(posedge clock);
        #1;
        s_axil_rready = 1'b0;
    endtask

    task automatic verify_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        logic [1:0] resp;
        logic [31:0] offset;
        bit hit;
        offset = addr - BASE;
        hit = (addr >= BASE) && (offset < 4 * N);
        write_reg(addr, data, strb, resp);
        if (resp != (hit ? 2'b00 : 2'b10)) begin
            report_error($sformatf("write to %h gave response %0d", addr, resp));
        end
        if (hit && strb[0]) begin
            shift_model[offset / 4][7:0] = data[7:0];
        end
        if (hit && strb[1]) begin
            shift_model[offset / 4][15:8] = data[15:8];
        end
    endtask

    task automatic verify_read(input logic [31:0] addr);
        logic [1:0] resp;
        logic [31:0] data;
        logic [31:0] offset;
        logic [31:0] expected;
        bit hit;
        offset = addr - BASE;
        hit = (addr >= BASE) && (offset < 4 * N);
        expected = hit ? {16'h0, shift_model[offset / 4]} : 32'h0;
        read_reg(addr, data, resp);
        if (data != expected || resp != (hit ? 2'b00 : 2'b10)) begin
            report_error($sformatf("read of %h gave %h resp %0d, expected %h",
                addr, data, resp, expected));
        end
    endtask

    task automatic send_angle(input sincos_pkg::angle_t angle, input int gap);
        idle(gap);
        phase_data = angle;
        phase_valid = 1'b1;
        do begin
            @(negedge clock);
        end while (!phase_ready);
        @(posedge clock);
        #1;
        phase_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (exp_chan.size() != 0) begin
            idle(1);
        end
        idle(4);
    endtask

    task automatic finish_test(input int num, input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("Test %0d (%s): passed", num, name);
        end else begin
            $display("Test %0d (%s): %0d errors", num, name, errors - errors_before);
        end
    endtask

    initial begin
        int mark;
        logic [31:0] addr;
        void'($urandom(48));
        reset = 1'b0;
        s_axil_awvalid = 1'b0;
        s_axil_awaddr = '0;
        s_axil_wvalid = 1'b0;
        s_axil_wdata = '0;
        s_axil_wstrb = '0;
        s_axil_bready = 1'b0;
        s_axil_arvalid = 1'b0;
        s_axil_araddr = '0;
        s_axil_rready = 1'b0;
        phase_valid = 1'b0;
        phase_data = '0;
        for (int k = 0; k < (1 << AW); k++) begin
            sine_table[k] = $rtoi(32767.0 * $sin(2.0 * PI * (k + 0.5) / (4.0 * (1 << AW))) + 0.5);
        end
        // Channels start evenly spaced around one turn
        for (int i = 0; i < N; i++) begin
            shift_model[i] = (i * 65536) / N;
        end
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b1;
        idle(2);

        mark = errors;
        for (int i = 0; i < N; i++) begin
            verify_read(BASE + 4 * i);
        end
        finish_test(1, "register defaults", mark);

        mark = errors;
        repeat (30) begin
            verify_write(BASE + 4 * ($urandom % N), $urandom, $urandom % 16);
        end
        repeat (8) begin
            addr = ($urandom % 2) ? BASE + 4 * (N + $urandom % 64) : BASE - 4 * (1 + $urandom % 64);
            verify_write(addr, $urandom, 4'hf);
            verify_read(addr);
        end
        for (int i = 0; i < N; i++) begin
            verify_read(BASE + 4 * i);
            verify_write(BASE + 4 * i, (i * 65536) / N, 4'h3);
        end
        finish_test(2, "register writes and errors", mark);

        mark = errors;
        repeat (100) begin
            send_angle($urandom, $urandom % 3);
        end
        wait_drain();
        finish_test(3, "default shifts", mark);

        mark = errors;
        for (int i = 0; i < N; i++) begin
            verify_write(BASE + 4 * i, $urandom, 4'hf);
        end
        repeat (100) begin
            send_angle($urandom, $urandom % 3);
        end
        wait_drain();
        finish_test(4, "random shifts", mark);

        mark = errors;
        last_accept = -1;
        hold_mode = 1;
        repeat (20) begin
            send_angle($urandom, 0);
        end
        hold_mode = 0;
        wait_drain();
        finish_test(5, "back to back angles", mark);

        // Register traffic runs alongside the angle stream but leaves the shifts alone
        mark = errors;
        stall_mode = 1;
        fork
            begin
                // Gaps longer than a sweep leave the input idle while ready is high
                repeat (30) begin
                    send_angle($urandom, $urandom % (2 * N));
                end
            end
            begin
                repeat (12) begin
                    verify_read(BASE + 4 * ($urandom % N));
                    verify_write(BASE + 4 * (N + $urandom % 8), $urandom, 4'hf);
                end
            end
        join
        stall_mode = 0;
        wait_drain();
        finish_test(6, "stalls and gaps", mark);

        idle(10);
        $display("Tests run: %0d, samples checked: %0d, errors: %0d", tests, samples, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/multiphase_sin_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sincos_defs.svh"

module multiphase_sin_top (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     s_axil_awvalid,
    output logic                    s_axil_awready,
    input  wire sincos_pkg::axil_addr_t s_axil_awaddr,
    input  wire                     s_axil_wvalid,
    output logic                    s_axil_wready,
    input  wire sincos_pkg::axil_data_t s_axil_wdata,
    input  wire [3:0]               s_axil_wstrb,
    output logic                    s_axil_bvalid,
    input  wire                     s_axil_bready,
    output sincos_pkg::axil_resp_t  s_axil_bresp,
    input  wire                     s_axil_arvalid,
    output logic                    s_axil_arready,
    input  wire sincos_pkg::axil_addr_t s_axil_araddr,
    output logic                    s_axil_rvalid,
    input  wire                     s_axil_rready,
    output sincos_pkg::axil_data_t  s_axil_rdata,
    output sincos_pkg::axil_resp_t  s_axil_rresp,
    input  wire                     phase_valid,
    output logic                    phase_ready,
    input  wire sincos_pkg::angle_t phase_data,
    output logic                    sin_valid,
    output sincos_pkg::sample_t     sin_data,
    output sincos_pkg::chan_t       sin_dest,
    output logic                    cos_valid,
    output sincos_pkg::sample_t     cos_data,
    output sincos_pkg::chan_t       cos_dest
);

    // Per-channel shifts from the host registers into the generator
    sincos_pkg::angle_t [`SINCOS_N_PHASES-1:0] phase_shifts;

    phase_shift_regs phase_shift_regs_i (
        .clock         (clock),
        .reset         (reset),
        .s_axil_awvalid(s_axil_awvalid),
        .s_axil_awready(s_axil_awready),
        .s_axil_awaddr (s_axil_awaddr),
        .s_axil_wvalid (s_axil_wvalid),
        .s_axil_wready (s_axil_wready),
        .s_axil_wdata  (s_axil_wdata),
        .s_axil_wstrb  (s_axil_wstrb),
        .s_axil_bvalid (s_axil_bvalid),
        .s_axil_bready (s_axil_bready),
        .s_axil_bresp  (s_axil_bresp),
        .s_axil_arvalid(s_axil_arvalid),
        .s_axil_arready(s_axil_arready),
        .s_axil_araddr (s_axil_araddr),
        .s_axil_rvalid (s_axil_rvalid),
        .s_axil_rready (s_axil_rready),
        .s_axil_rdata  (s_axil_rdata),
        .s_axil_rresp  (s_axil_rresp),
        .phase_shifts  (phase_shifts)
    );

    multiphase_sinusoid_generator generator_i (
        .clock       (clock),
        .reset       (reset),
        .phase_shifts(phase_shifts),
        .phase_valid (phase_valid),
        .phase_ready (phase_ready),
        .phase_data  (phase_data),
        .sin_valid   (sin_valid),
        .sin_data    (sin_data),
        .sin_dest    (sin_dest),
        .cos_valid   (cos_valid),
        .cos_data    (cos_data),
        .cos_dest    (cos_dest)
    );

endmodule

`default_nettype wire

//--- hw/phase_shift_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "sincos_defs.svh"

module phase_shift_regs (
    input  wire                     clock,
    input  wire                     reset,
    input  wire                     s_axil_awvalid,
    output logic                    s_axil_awready,
    input  wire sincos_pkg::axil_addr_t s_axil_awaddr,
    input  wire                     s_axil_wvalid,
    output logic                    s_axil_wready,
    input  wire sincos_pkg::axil_data_t s_axil_wdata,
    input  wire [3:0]               s_axil_wstrb,
    output logic                    s_axil_bvalid,
    input  wire                     s_axil_bready,
    output sincos_pkg::axil_resp_t  s_axil_bresp,
    input  wire                     s_axil_arvalid,
    output logic                    s_axil_arready,
    input  wire sincos_pkg::axil_addr_t s_axil_araddr,
    output logic                    s_axil_rvalid,
    input  wire                     s_axil_rready,
    output sincos_pkg::axil_data_t  s_axil_rdata,
    output sincos_pkg::axil_resp_t  s_axil_rresp,
    output sincos_pkg::angle_t [`SINCOS_N_PHASES-1:0] phase_shifts
);

    localparam int N = `SINCOS_N_PHASES;
    localparam int STORED_BYTES = `SINCOS_DATA_WIDTH / 8;
    localparam sincos_pkg::axil_resp_t RESP_OKAY = 2'b00;
    localparam sincos_pkg::axil_resp_t RESP_SLVERR = 2'b10;

    sincos_pkg::axil_wr_state_e wr_state;
    sincos_pkg::axil_addr_t aw_addr_q;
    sincos_pkg::axil_data_t w_data_q;
    logic [3:0] w_strb_q;

    logic aw_hs;
    logic w_hs;
    logic ar_hs;
    logic wr_commit;
    sincos_pkg::axil_addr_t wr_addr;
    sincos_pkg::axil_data_t wr_data;
    logic [3:0] wr_strb;

    // Only offsets 0 .. 4*N-1 above the base address are backed by registers
    function automatic logic addr_hit(input sincos_pkg::axil_addr_t addr);
        sincos_pkg::axil_addr_t offset;
        offset = addr - sincos_pkg::axil_addr_t'(`SINCOS_BASE_ADDR);
        return (addr >= sincos_pkg::axil_addr_t'(`SINCOS_BASE_ADDR)) &&
               (offset < sincos_pkg::axil_addr_t'(4 * N));
    endfunction

    function automatic sincos_pkg::chan_t addr_index(input sincos_pkg::axil_addr_t addr);
        sincos_pkg::axil_addr_t offset;
        offset = addr - sincos_pkg::axil_addr_t'(`SINCOS_BASE_ADDR);
        return offset[2 +: $bits(sincos_pkg::chan_t)];
    endfunction

    assign aw_hs = s_axil_awvalid && s_axil_awready;
    assign w_hs = s_axil_wvalid && s_axil_wready;
    assign ar_hs = s_axil_arvalid && s_axil_arready;

    // Address and data may arrive in either order, so use whichever is live this cycle
    assign wr_addr = aw_hs ? s_axil_awaddr : aw_addr_q;
    assign wr_data = w_hs ? s_axil_wdata : w_data_q;
    assign wr_strb = w_hs ? s_axil_wstrb : w_strb_q;

    always_comb begin
        case (wr_state)
            sincos_pkg::wr_idle: wr_commit = aw_hs && w_hs;
            sincos_pkg::wr_wait_data: wr_commit = w_hs;
            sincos_pkg::wr_wait_addr: wr_commit = aw_hs;
            default: wr_commit = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_state <= sincos_pkg::wr_idle;
            s_axil_awready <= 1'b0;
            s_axil_wready <= 1'b0;
            s_axil_bvalid <= 1'b0;
            s_axil_bresp <= RESP_OKAY;
        end else if (wr_commit) begin
            s_axil_awready <= 1'b0;
            s_axil_wready <= 1'b0;
            s_axil_bvalid <= 1'b1;
            s_axil_bresp <= addr_hit(wr_addr) ? RESP_OKAY : RESP_SLVERR;
            wr_state <= sincos_pkg::wr_resp;
        end else begin
            case (wr_state)
                sincos_pkg::wr_idle: begin
                    if (aw_hs) begin
                        s_axil_awready <= 1'b0;
                        wr_state <= sincos_pkg::wr_wait_data;
                    end else if (w_hs) begin
                        s_axil_wready <= 1'b0;
                        wr_state <= sincos_pkg::wr_wait_addr;
                    end else begin
                        s_axil_awready <= 1'b1;
                        s_axil_wready <= 1'b1;
                    end
                end
                sincos_pkg::wr_resp: begin
                    if (s_axil_bready) begin
                        s_axil_bvalid <= 1'b0;
                        s_axil_awready <= 1'b1;
                        s_axil_wready <= 1'b1;
                        wr_state <= sincos_pkg::wr_idle;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_addr_q <= s_axil_awaddr;
        end
        if (w_hs) begin
            w_data_q <= s_axil_wdata;
            w_strb_q <= s_axil_wstrb;
        end
        if (ar_hs) begin
            s_axil_rdata <= addr_hit(s_axil_araddr) ?
                sincos_pkg::axil_data_t'(phase_shifts[addr_index(s_axil_araddr)]) : '0;
        end
    end

    // Shifts start evenly spaced around the turn, upper strobes are ignored
    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < N; i++) begin
                phase_shifts[i] <= sincos_pkg::angle_t'((i * (1 << `SINCOS_DATA_WIDTH)) / N);
            end
        end else if (wr_commit && addr_hit(wr_addr)) begin
            for (int b = 0; b < STORED_BYTES; b++) begin
                if (wr_strb[b]) begin
                    phase_shifts[addr_index(wr_addr)][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid <= 1'b0;
            s_axil_rresp <= RESP_OKAY;
        end else if (ar_hs) begin
            s_axil_arready <= 1'b0;
            s_axil_rvalid <= 1'b1;
            s_axil_rresp <= addr_hit(s_axil_araddr) ? RESP_OKAY : RESP_SLVERR;
        end else if (s_axil_rvalid && s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
            s_axil_arready <= 1'b1;
        end else if (!s_axil_rvalid) begin
            s_axil_arready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- sinusoid_gen/multiphase_sinusoid_generator.sv
`timescale 1ns/1ps
`default_nettype none

`include "sincos_defs.svh"

module multiphase_sinusoid_generator (
    input  wire                    clock,
    input  wire                    reset,
    input  wire sincos_pkg::angle_t [`SINCOS_N_PHASES-1:0] phase_shifts,
    input  wire                    phase_valid,
    output logic                   phase_ready,
    input  wire sincos_pkg::angle_t phase_data,
    output logic                   sin_valid,
    output sincos_pkg::sample_t    sin_data,
    output sincos_pkg::chan_t      sin_dest,
    output logic                   cos_valid,
    output sincos_pkg::sample_t    cos_data,
    output sincos_pkg::chan_t      cos_dest
);

    localparam int N = `SINCOS_N_PHASES;

    sincos_pkg::seq_state_e state;
    sincos_pkg::chan_t issue_count;
    sincos_pkg::angle_t latched_phase;
    sincos_pkg::angle_t lut_theta;
    logic [N-1:0] lut_enable;
    logic accept;

    logic [N-1:0] lut_sin_valid;
    logic [N-1:0] lut_cos_valid;
    sincos_pkg::sample_t lut_sin_data [N];
    sincos_pkg::sample_t lut_cos_data [N];
    sincos_pkg::chan_t lut_dest [N];

    logic merged_sin_valid;
    logic merged_cos_valid;
    sincos_pkg::sample_t merged_sin_data;
    sincos_pkg::sample_t merged_cos_data;
    sincos_pkg::chan_t merged_sin_dest;
    sincos_pkg::chan_t merged_cos_dest;

    assign accept = phase_valid && phase_ready;

    // One channel is issued per cycle, the input is closed while a sweep is running
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= sincos_pkg::seq_idle;
            phase_ready <= 1'b1;
            issue_count <= '0;
            lut_enable <= '0;
        end else begin
            lut_enable <= '0;
            case (state)
                sincos_pkg::seq_idle: begin
                    if (accept) begin
                        phase_ready <= 1'b0;
                        issue_count <= '0;
                        state <= sincos_pkg::seq_issue;
                    end
                end
                sincos_pkg::seq_issue: begin
                    lut_enable[issue_count] <= 1'b1;
                    if (issue_count == sincos_pkg::chan_t'(N - 1)) begin
                        phase_ready <= 1'b1;
                        state <= sincos_pkg::seq_idle;
                    end else begin
                        issue_count <= issue_count + 1'b1;
                    end
                end
                default: state <= sincos_pkg::seq_idle;
            endcase
        end
    end

    // The sum wraps naturally at one turn; a single theta is shared since one lookup runs at a time
    always_ff @(posedge clock) begin
        if (accept) begin
            latched_phase <= phase_data;
        end
        if (state == sincos_pkg::seq_issue) begin
            lut_theta <= latched_phase + phase_shifts[issue_count];
        end
    end

    for (genvar i = 0; i < N; i++) begin : g_lut
        sin_cos_lut lut_i (
            .clock      (clock),
            .reset      (reset),
            .theta_valid(lut_enable[i]),
            .theta      (lut_theta),
            .theta_dest (sincos_pkg::chan_t'(i)),
            .sin_valid  (lut_sin_valid[i]),
            .sin_data   (lut_sin_data[i]),
            .cos_valid  (lut_cos_valid[i]),
            .cos_data   (lut_cos_data[i]),
            .dest       (lut_dest[i])
        );
    end

    // Lookups never overlap, so masking by valid and OR-ing selects the active one
    always_comb begin
        merged_sin_valid = 1'b0;
        merged_cos_valid = 1'b0;
        merged_sin_data = '0;
        merged_cos_data = '0;
        merged_sin_dest = '0;
        merged_cos_dest = '0;
        for (int j = 0; j < N; j++) begin
            if (lut_sin_valid[j]) begin
                merged_sin_valid = 1'b1;
                merged_sin_data = merged_sin_data | lut_sin_data[j];
                merged_sin_dest = merged_sin_dest | lut_dest[j];
            end
            if (lut_cos_valid[j]) begin
                merged_cos_valid = 1'b1;
                merged_cos_data = merged_cos_data | lut_cos_data[j];
                merged_cos_dest = merged_cos_dest | lut_dest[j];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            sin_valid <= 1'b0;
            cos_valid <= 1'b0;
        end else begin
            sin_valid <= merged_sin_valid;
            cos_valid <= merged_cos_valid;
        end
    end

    always_ff @(posedge clock) begin
        sin_data <= merged_sin_data;
        sin_dest <= merged_sin_dest;
        cos_data <= merged_cos_data;
        cos_dest <= merged_cos_dest;
    end

endmodule

`default_nettype wire

//--- sinusoid_gen/sin_cos_lut.sv
`timescale 1ns/1ps
`default_nettype none

`include "sincos_defs.svh"

module sin_cos_lut (
    input  wire                      clock,
    input  wire                      reset,
    input  wire                      theta_valid,
    input  wire sincos_pkg::angle_t  theta,
    input  wire sincos_pkg::chan_t   theta_dest,
    output logic                     sin_valid,
    output sincos_pkg::sample_t      sin_data,
    output logic                     cos_valid,
    output sincos_pkg::sample_t      cos_data,
    output sincos_pkg::chan_t        dest
);

    localparam int DW = `SINCOS_DATA_WIDTH;
    localparam int AW = `SINCOS_LUT_ADDR_BITS;
    localparam int LUT_SIZE = 1 << AW;
    localparam real PI = 3.14159265358979;
    localparam real AMPLITUDE = (2.0 ** (DW - 1)) - 1.0;
    localparam sincos_pkg::angle_t QUARTER_TURN = sincos_pkg::angle_t'(1 << (DW - 2));

    typedef sincos_pkg::sample_t table_t [LUT_SIZE];

    // Entries are sampled at the middle of each step, so the table folds without an extra point
    function automatic table_t build_table();
        table_t t;
        real arg;
        for (int k = 0; k < LUT_SIZE; k++) begin
            arg = 2.0 * PI * (k + 0.5) / (4.0 * LUT_SIZE);
            t[k] = sincos_pkg::sample_t'($rtoi(AMPLITUDE * $sin(arg) + 0.5));
        end
        return t;
    endfunction

    localparam table_t SIN_TABLE = build_table();

    sincos_pkg::angle_t theta_cos;
    logic [AW-1:0] sin_addr_next;
    logic [AW-1:0] cos_addr_next;

    logic s1_valid;
    sincos_pkg::chan_t s1_dest;
    logic [AW-1:0] s1_sin_addr;
    logic [AW-1:0] s1_cos_addr;
    logic [1:0] s1_sin_quad;
    logic [1:0] s1_cos_quad;

    // Cosine is the sine a quarter turn ahead
    assign theta_cos = theta + QUARTER_TURN;

    // Odd quadrants run the table backwards
    assign sin_addr_next = theta[DW-1-2 -: AW] ^ {AW{theta[DW-2]}};
    assign cos_addr_next = theta_cos[DW-1-2 -: AW] ^ {AW{theta_cos[DW-2]}};

    always_ff @(posedge clock) begin
        if (!reset) begin
            s1_valid <= 1'b0;
            sin_valid <= 1'b0;
            cos_valid <= 1'b0;
        end else begin
            s1_valid <= theta_valid;
            sin_valid <= s1_valid;
            cos_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_dest <= theta_dest;
        s1_sin_addr <= sin_addr_next;
        s1_cos_addr <= cos_addr_next;
        s1_sin_quad <= theta[DW-1 -: 2];
        s1_cos_quad <= theta_cos[DW-1 -: 2];

        // Second half of the turn is the negated first half
        dest <= s1_dest;
        sin_data <= s1_sin_quad[1] ? -SIN_TABLE[s1_sin_addr] : SIN_TABLE[s1_sin_addr];
        cos_data <= s1_cos_quad[1] ? -SIN_TABLE[s1_cos_addr] : SIN_TABLE[s1_cos_addr];
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+common
common/sincos_pkg.sv
hw/phase_shift_regs.sv
sinusoid_gen/sin_cos_lut.sv
sinusoid_gen/multiphase_sinusoid_generator.sv
hw/multiphase_sin_top.sv
dv/multiphase_sin_props.sv
dv/multiphase_sin_tb.sv
